// File: design/angle_calc_macros.svh
`ifndef ANGLE_CALC_MACROS_SVH
`define ANGLE_CALC_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// Data widths
//////////////////////////////////////////////////////////////////////

`define ANGLE_W            16      // Angle and step wrap mod 2^16
`define MODE_W             16      // Raw mode word from the controller

//////////////////////////////////////////////////////////////////////
// Converter geometry
//////////////////////////////////////////////////////////////////////

`define CELLS_PER_PHASE    24
`define NUM_PHASES         3
`define CELL_IDX_W         5
`define PHASE_IDX_W        2

// Mode word that restarts phases B and C at zero
`define MODE_RESTART_CODE  16'h55aa

`endif

// File: design/angle_calc_top.sv
`timescale 1ns/1ps
`include "angle_calc_macros.svh"

module angle_calc_top (
  input  logic                          i_clk_20M,
  input  logic                          i_reset_n,
  input  logic                          i_start_valid,
  input  logic [`MODE_W-1:0]            i_mode,
  input  angle_types_pkg::angle_t       i_shift_a,
  input  angle_types_pkg::angle_t       i_shift_b,
  input  angle_types_pkg::angle_t       i_shift_c,
  input  angle_types_pkg::bypass_mask_t i_bypass_a,
  input  angle_types_pkg::bypass_mask_t i_bypass_b,
  input  angle_types_pkg::bypass_mask_t i_bypass_c,
  input  logic                          i_angle_ready,
  output logic                          o_start_ready,
  output logic                          o_angle_valid,
  output angle_types_pkg::angle_t       o_angle,
  output angle_types_pkg::phase_e       o_phase,
  output angle_types_pkg::cell_idx_t    o_cell
);

  logic                       load;
  logic                       advance;
  logic                       next_first;
  angle_types_pkg::phase_e    next_phase;
  angle_types_pkg::cell_idx_t next_cell;
  angle_types_pkg::angle_t    shift;
  logic                       bypass_cur;
  logic                       bypass_prev;
  angle_ctrl_pkg::calc_mode_e mode;

  cell_sequencer i_cell_sequencer (
    .i_clk_20M     (i_clk_20M),
    .i_reset_n     (i_reset_n),
    .i_start_valid (i_start_valid),
    .i_angle_ready (i_angle_ready),
    .o_start_ready (o_start_ready),
    .o_angle_valid (o_angle_valid),
    .o_load        (load),
    .o_advance     (advance),
    .o_phase       (o_phase),
    .o_cell        (o_cell),
    .o_next_phase  (next_phase),
    .o_next_cell   (next_cell),
    .o_next_first  (next_first)
  );

  carrier_config_latch i_carrier_config_latch (
    .i_clk_20M     (i_clk_20M),
    .i_reset_n     (i_reset_n),
    .i_load        (load),
    .i_mode        (i_mode),
    .i_shift_a     (i_shift_a),
    .i_shift_b     (i_shift_b),
    .i_shift_c     (i_shift_c),
    .i_bypass_a    (i_bypass_a),
    .i_bypass_b    (i_bypass_b),
    .i_bypass_c    (i_bypass_c),
    .i_next_phase  (next_phase),
    .i_next_cell   (next_cell),
    .o_shift       (shift),
    .o_bypass_cur  (bypass_cur),
    .o_bypass_prev (bypass_prev),
    .o_mode        (mode)
  );

  phase_angle_accumulator i_phase_angle_accumulator (
    .i_clk_20M     (i_clk_20M),
    .i_reset_n     (i_reset_n),
    .i_load        (load),
    .i_advance     (advance),
    .i_next_first  (next_first),
    .i_next_cell   (next_cell),
    .i_shift       (shift),
    .i_bypass_cur  (bypass_cur),
    .i_bypass_prev (bypass_prev),
    .i_mode        (mode),
    .o_angle       (o_angle)
  );

endmodule

// File: design/angle_ctrl_pkg.sv
package angle_ctrl_pkg;

  // Output sequencer
  typedef enum logic [1:0] {
    SEQ_IDLE = 2'd0,  // Waiting for a start
    SEQ_EMIT = 2'd1,  // Item presented on the stream
    SEQ_STEP = 2'd2   // Gap cycle while the next angle settles
  } seq_state_e;

  // How the first cell of phases B and C begins
  typedef enum logic {
    MODE_CHAINED = 1'b0,
    MODE_RESTART = 1'b1
  } calc_mode_e;

endpackage

// File: design/angle_types_pkg.sv
`include "angle_calc_macros.svh"

package angle_types_pkg;

  // Unsigned carrier angle that wraps
  typedef logic [`ANGLE_W-1:0] angle_t;

  typedef enum logic [`PHASE_IDX_W-1:0] {
    PHASE_A = 2'd0,
    PHASE_B = 2'd1,
    PHASE_C = 2'd2
  } phase_e;

  // Cell number 0..23 within a phase
  typedef logic [`CELL_IDX_W-1:0] cell_idx_t;

  // Bit k set means cell k+1 is bypassed
  typedef logic [`CELLS_PER_PHASE-1:0] bypass_mask_t;

endpackage

// File: design/carrier_config_latch.sv
`timescale 1ns/1ps
`include "angle_calc_macros.svh"

module carrier_config_latch (
  input  logic                          i_clk_20M,
  input  logic                          i_reset_n,
  input  logic                          i_load,
  input  logic [`MODE_W-1:0]            i_mode,
  input  angle_types_pkg::angle_t       i_shift_a,
  input  angle_types_pkg::angle_t       i_shift_b,
  input  angle_types_pkg::angle_t       i_shift_c,
  input  angle_types_pkg::bypass_mask_t i_bypass_a,
  input  angle_types_pkg::bypass_mask_t i_bypass_b,
  input  angle_types_pkg::bypass_mask_t i_bypass_c,
  input  angle_types_pkg::phase_e       i_next_phase,
  input  angle_types_pkg::cell_idx_t    i_next_cell,
  output angle_types_pkg::angle_t       o_shift,
  output logic                          o_bypass_cur,
  output logic                          o_bypass_prev,
  output angle_ctrl_pkg::calc_mode_e    o_mode
);

  angle_types_pkg::angle_t       shift_a_q;
  angle_types_pkg::angle_t       shift_b_q;
  angle_types_pkg::angle_t       shift_c_q;
  angle_types_pkg::bypass_mask_t mask_a_q;
  angle_types_pkg::bypass_mask_t mask_b_q;
  angle_types_pkg::bypass_mask_t mask_c_q;

  angle_types_pkg::angle_t       sel_shift;
  angle_types_pkg::bypass_mask_t sel_mask;
  logic                          sel_prev;

  always_ff @(posedge i_clk_20M) begin
    if (i_load) begin
      shift_a_q <= i_shift_a;
      shift_b_q <= i_shift_b;
      shift_c_q <= i_shift_c;
      mask_a_q  <= i_bypass_a;
      mask_b_q  <= i_bypass_b;
      mask_c_q  <= i_bypass_c;
    end
  end

  // Ports bypass the latch on the load cycle so cell 1 is ready at once
  always_comb begin
    case (i_next_phase)
      angle_types_pkg::PHASE_B: begin
        sel_shift = shift_b_q;
        sel_mask  = mask_b_q;
      end
      angle_types_pkg::PHASE_C: begin
        sel_shift = shift_c_q;
        sel_mask  = mask_c_q;
      end
      default: begin
        sel_shift = i_load ? i_shift_a : shift_a_q;
        sel_mask  = i_load ? i_bypass_a : mask_a_q;
      end
    endcase
    // No cell before the first one
    if (i_next_cell == '0) begin
      sel_prev = 1'b0;
    end else begin
      sel_prev = sel_mask[i_next_cell - angle_types_pkg::cell_idx_t'(1)];
    end
  end

  always_ff @(posedge i_clk_20M) begin
    if (!i_reset_n) begin
      o_mode        <= angle_ctrl_pkg::MODE_CHAINED;
      o_shift       <= '0;
      o_bypass_cur  <= 1'b0;
      o_bypass_prev <= 1'b0;
    end else begin
      if (i_load) begin
        o_mode <= (i_mode == `MODE_RESTART_CODE) ? angle_ctrl_pkg::MODE_RESTART
                                                 : angle_ctrl_pkg::MODE_CHAINED;
      end
      o_shift       <= sel_shift;
      o_bypass_cur  <= sel_mask[i_next_cell];
      o_bypass_prev <= sel_prev;
    end
  end

endmodule

// File: design/cell_sequencer.sv
`timescale 1ns/1ps
`include "angle_calc_macros.svh"

module cell_sequencer (
  input  logic                       i_clk_20M,
  input  logic                       i_reset_n,
  input  logic                       i_start_valid,
  input  logic                       i_angle_ready,
  output logic                       o_start_ready,
  output logic                       o_angle_valid,
  output logic                       o_load,
  output logic                       o_advance,
  output angle_types_pkg::phase_e    o_phase,
  output angle_types_pkg::cell_idx_t o_cell,
  output angle_types_pkg::phase_e    o_next_phase,
  output angle_types_pkg::cell_idx_t o_next_cell,
  output logic                       o_next_first
);

  angle_ctrl_pkg::seq_state_e state_q;

  logic                       start_fire;
  logic                       out_fire;
  logic                       last_item;
  angle_types_pkg::phase_e    inc_phase;
  angle_types_pkg::cell_idx_t inc_cell;
  logic                       inc_first;

  assign start_fire = i_start_valid & o_start_ready;
  assign out_fire   = o_angle_valid & i_angle_ready;
  assign last_item  = (o_phase == angle_types_pkg::PHASE_C) &&
                      (o_cell == angle_types_pkg::cell_idx_t'(`CELLS_PER_PHASE - 1));

  assign o_load    = start_fire;
  assign o_advance = out_fire & ~last_item;

  // Cell after the next one wraps into the following phase
  always_comb begin
    inc_phase = o_next_phase;
    inc_cell  = o_next_cell + angle_types_pkg::cell_idx_t'(1);
    if (o_next_cell == angle_types_pkg::cell_idx_t'(`CELLS_PER_PHASE - 1)) begin
      inc_cell = '0;
      case (o_next_phase)
        angle_types_pkg::PHASE_A: inc_phase = angle_types_pkg::PHASE_B;
        angle_types_pkg::PHASE_B: inc_phase = angle_types_pkg::PHASE_C;
        default:                  inc_phase = angle_types_pkg::PHASE_A;
      endcase
    end
    inc_first = (inc_cell == '0) && (inc_phase != angle_types_pkg::PHASE_A);
  end

  //////////////////////////////////////////////////////////////////////
  // Handshake FSM and index registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_clk_20M) begin
    if (!i_reset_n) begin
      state_q       <= angle_ctrl_pkg::SEQ_IDLE;
      o_start_ready <= 1'b1;
      o_angle_valid <= 1'b0;
      o_phase       <= angle_types_pkg::PHASE_A;
      o_cell        <= '0;
      o_next_phase  <= angle_types_pkg::PHASE_A;
      o_next_cell   <= angle_types_pkg::cell_idx_t'(1);
      o_next_first  <= 1'b0;
    end else begin
      case (state_q)
        angle_ctrl_pkg::SEQ_IDLE: begin
          if (start_fire) begin
            state_q       <= angle_ctrl_pkg::SEQ_EMIT;
            o_start_ready <= 1'b0;
            o_angle_valid <= 1'b1;
            o_phase       <= angle_types_pkg::PHASE_A;
            o_cell        <= '0;
          end
        end
        angle_ctrl_pkg::SEQ_EMIT: begin
          if (out_fire) begin
            o_angle_valid <= 1'b0;
            if (last_item) begin
              state_q       <= angle_ctrl_pkg::SEQ_IDLE;
              o_start_ready <= 1'b1;
              o_next_phase  <= angle_types_pkg::PHASE_A;  // Parked on A cell 1
              o_next_cell   <= angle_types_pkg::cell_idx_t'(1);
              o_next_first  <= 1'b0;
            end else begin
              state_q      <= angle_ctrl_pkg::SEQ_STEP;
              o_phase      <= o_next_phase;
              o_cell       <= o_next_cell;
              o_next_phase <= inc_phase;
              o_next_cell  <= inc_cell;
              o_next_first <= inc_first;
            end
          end
        end
        angle_ctrl_pkg::SEQ_STEP: begin
          state_q       <= angle_ctrl_pkg::SEQ_EMIT;
          o_angle_valid <= 1'b1;
        end
        default: begin
          state_q       <= angle_ctrl_pkg::SEQ_IDLE;
          o_start_ready <= 1'b1;
          o_angle_valid <= 1'b0;
        end
      endcase
    end
  end

  // Stalled item holds until taken
  a_stall_stable : assert property (
    @(posedge i_clk_20M) disable iff (!i_reset_n)
    o_angle_valid && !i_angle_ready |=>
      o_angle_valid && $stable(o_phase) && $stable(o_cell)
  );

  a_index_range : assert property (
    @(posedge i_clk_20M) disable iff (!i_reset_n)
    int'(o_cell) < `CELLS_PER_PHASE && int'(o_next_cell) < `CELLS_PER_PHASE &&
      int'(o_phase) < `NUM_PHASES
  );

endmodule

// File: design/phase_angle_accumulator.sv
`timescale 1ns/1ps

module phase_angle_accumulator (
  input  logic                       i_clk_20M,
  input  logic                       i_reset_n,
  input  logic                       i_load,
  input  logic                       i_advance,
  input  logic                       i_next_first,
  input  angle_types_pkg::cell_idx_t i_next_cell,
  input  angle_types_pkg::angle_t    i_shift,
  input  logic                       i_bypass_cur,
  input  logic                       i_bypass_prev,
  input  angle_ctrl_pkg::calc_mode_e i_mode,
  output angle_types_pkg::angle_t    o_angle
);

  angle_types_pkg::angle_t angle_stepped;
  angle_types_pkg::angle_t angle_next;
  logic                    is_cell_two;

  assign angle_stepped = o_angle + i_shift;  // Wraps mod 2^16
  assign is_cell_two   = (i_next_cell == angle_types_pkg::cell_idx_t'(1));

  //////////////////////////////////////////////////////////////////////
  // Angle rules for the cell being computed
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    if (i_next_first) begin
      // Hand-over into phase B or C
      if (i_mode == angle_ctrl_pkg::MODE_RESTART) begin
        angle_next = '0;
      end else if (i_bypass_cur) begin
        angle_next = o_angle;
      end else begin
        angle_next = angle_stepped;
      end
    end else if (is_cell_two) begin
      // Also held when cell 1 is out
      if (i_bypass_cur || i_bypass_prev) begin
        angle_next = o_angle;
      end else begin
        angle_next = angle_stepped;
      end
    end else if (i_bypass_cur) begin
      angle_next = o_angle;
    end else begin
      angle_next = angle_stepped;
    end
  end

  always_ff @(posedge i_clk_20M) begin
    if (!i_reset_n) begin
      o_angle <= '0;
    end else if (i_load) begin
      o_angle <= '0;           // Phase A cell 1
    end else if (i_advance) begin
      o_angle <= angle_next;
    end
  end

  // Sequencer must never start and step in one cycle
  a_load_advance_excl : assert property (
    @(posedge i_clk_20M) disable iff (!i_reset_n)
    !(i_load && i_advance)
  );

endmodule

// File: project.f
+incdir+design
+incdir+sim
design/angle_types_pkg.sv
design/angle_ctrl_pkg.sv
design/carrier_config_latch.sv
design/phase_angle_accumulator.sv
design/cell_sequencer.sv
design/angle_calc_top.sv
sim/tb_angle_calc.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f project.f --top-module tb_angle_calc -o tb_angle_calc

./obj_dir/tb_angle_calc > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: PASS" sim.log; then
  exit 0
fi
exit 1

// File: sim/tb_angle_model.svh
`ifndef TB_ANGLE_MODEL_SVH
`define TB_ANGLE_MODEL_SVH

// Full-period 32-bit LCG
function automatic logic [31:0] lcg_step(input logic [31:0] state);
  return state * 32'd1664525 + 32'd1013904223;
endfunction

//////////////////////////////////////////////////////////////////////
// Expected angles of one set with item n at [n*ANGLE_W +: ANGLE_W]
//////////////////////////////////////////////////////////////////////

function automatic logic [`NUM_PHASES*`CELLS_PER_PHASE*`ANGLE_W-1:0] model_angles(
  input logic [`ANGLE_W-1:0]         step_a,
  input logic [`ANGLE_W-1:0]         step_b,
  input logic [`ANGLE_W-1:0]         step_c,
  input logic [`CELLS_PER_PHASE-1:0] mask_a,
  input logic [`CELLS_PER_PHASE-1:0] mask_b,
  input logic [`CELLS_PER_PHASE-1:0] mask_c,
  input logic                        restart
);
  logic [`NUM_PHASES*`CELLS_PER_PHASE*`ANGLE_W-1:0] result;
  logic [`ANGLE_W-1:0]                              angle;
  logic [`ANGLE_W-1:0]                              step;
  logic [`CELLS_PER_PHASE-1:0]                      mask;
  int                                               p;
  int                                               c;
  int                                               n;
  result = '0;
  angle  = '0;
  n      = 0;
  for (p = 0; p < `NUM_PHASES; p++) begin
    step = (p == 0) ? step_a : (p == 1) ? step_b : step_c;
    mask = (p == 0) ? mask_a : (p == 1) ? mask_b : mask_c;
    for (c = 0; c < `CELLS_PER_PHASE; c++) begin
      if (c == 0 && (p == 0 || restart)) begin
        angle = '0;
      end else if (c == 1) begin
        // Cell 2 holds if cell 1 or cell 2 is out
        if (!mask[0] && !mask[1]) begin
          angle = angle + step;
        end
      end else if (!mask[c]) begin
        angle = angle + step;  // Chained hand-over lands here too
      end
      result[n*`ANGLE_W +: `ANGLE_W] = angle;
      n++;
    end
  end
  return result;
endfunction

`endif

// File: sim/tb_angle_calc.sv
`timescale 1ns/1ps
`include "angle_calc_macros.svh"

module tb_angle_calc;

  localparam int NUM_ITEMS  = `NUM_PHASES * `CELLS_PER_PHASE;
  localparam int WAIT_LIMIT = 100;
  localparam int SET_LIMIT  = 2000;  // Cycles for one full stream

  logic                          i_clk_20M;
  logic                          i_reset_n;
  logic                          i_start_valid;
  logic [`MODE_W-1:0]            i_mode;
  angle_types_pkg::angle_t       i_shift_a;
  angle_types_pkg::angle_t       i_shift_b;
  angle_types_pkg::angle_t       i_shift_c;
  angle_types_pkg::bypass_mask_t i_bypass_a;
  angle_types_pkg::bypass_mask_t i_bypass_b;
  angle_types_pkg::bypass_mask_t i_bypass_c;
  logic                          i_angle_ready;
  logic                          o_start_ready;
  logic                          o_angle_valid;
  angle_types_pkg::angle_t       o_angle;
  angle_types_pkg::phase_e       o_phase;
  angle_types_pkg::cell_idx_t    o_cell;

  logic [31:0]                   rng_state;
  int                            error_count;
  int                            timeout_count;
  logic [NUM_ITEMS*`ANGLE_W-1:0] expected;

  `include "tb_angle_model.svh"

  angle_calc_top i_angle_calc_top (
    .i_clk_20M     (i_clk_20M),
    .i_reset_n     (i_reset_n),
    .i_start_valid (i_start_valid),
    .i_mode        (i_mode),
    .i_shift_a     (i_shift_a),
    .i_shift_b     (i_shift_b),
    .i_shift_c     (i_shift_c),
    .i_bypass_a    (i_bypass_a),
    .i_bypass_b    (i_bypass_b),
    .i_bypass_c    (i_bypass_c),
    .i_angle_ready (i_angle_ready),
    .o_start_ready (o_start_ready),
    .o_angle_valid (o_angle_valid),
    .o_angle       (o_angle),
    .o_phase       (o_phase),
    .o_cell        (o_cell)
  );

  initial begin
    i_clk_20M = 1'b0;
    forever #25 i_clk_20M = ~i_clk_20M;
  end

  function logic [31:0] next_random();
    rng_state = lcg_step(rng_state);
    return rng_state;
  endfunction

  // About one stall in four when enabled
  function logic pick_ready(input logic use_stalls);
    logic [31:0] rnd;
    rnd = next_random();
    return !use_stalls || rnd[31] || rnd[30];
  endfunction

  task automatic compare_value(input string name, input logic [31:0] actual,
                               input logic [31:0] exp_val);
    if (actual !== exp_val) begin
      error_count++;
      $display("ERROR %s: got 0x%0h, expected 0x%0h at %0t", name, actual, exp_val, $time);
    end
  endtask

  task automatic wait_start_ready();
    int cycles;
    cycles = 0;
    @(negedge i_clk_20M);
    while (!o_start_ready && cycles < WAIT_LIMIT) begin
      @(negedge i_clk_20M);
      cycles++;
    end
    if (!o_start_ready) begin
      timeout_count++;
      $display("Timeout: the start handshake never became ready");
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // One start and the full 72-item stream
  //////////////////////////////////////////////////////////////////////

  task automatic run_set(input logic restart, input logic use_bypass, input logic use_stalls);
    logic [31:0]                   rnd;
    angle_types_pkg::angle_t       sa;
    angle_types_pkg::angle_t       sb;
    angle_types_pkg::angle_t       sc;
    angle_types_pkg::bypass_mask_t ma;
    angle_types_pkg::bypass_mask_t mb;
    angle_types_pkg::bypass_mask_t mc;
    logic [`MODE_W-1:0]            mode_word;
    angle_types_pkg::angle_t       exp_angle;
    angle_types_pkg::angle_t       closed;
    angle_types_pkg::angle_t       held_angle;
    angle_types_pkg::phase_e       held_phase;
    angle_types_pkg::cell_idx_t    held_cell;
    logic                          stalled;
    int                            count;
    int                            cycles;
    int                            exp_phase;
    int                            exp_cell;
    rnd = next_random();
    sa  = rnd[31:16];
    rnd = next_random();
    sb  = rnd[31:16];
    rnd = next_random();
    sc  = rnd[31:16];
    ma  = '0;
    mb  = '0;
    mc  = '0;
    if (use_bypass) begin
      rnd = next_random();
      ma  = rnd[31:8];
      rnd = next_random();
      mb  = rnd[31:8];
      rnd = next_random();
      mc  = rnd[31:8];
    end
    rnd       = next_random();
    mode_word = restart ? `MODE_RESTART_CODE : rnd[31:16];
    if (!restart && mode_word == `MODE_RESTART_CODE) begin
      mode_word = ~mode_word;
    end
    expected = model_angles(sa, sb, sc, ma, mb, mc, restart);

    wait_start_ready();
    @(posedge i_clk_20M);
    i_start_valid <= 1'b1;
    i_mode        <= mode_word;
    i_shift_a     <= sa;
    i_shift_b     <= sb;
    i_shift_c     <= sc;
    i_bypass_a    <= ma;
    i_bypass_b    <= mb;
    i_bypass_c    <= mc;
    wait_start_ready();
    @(posedge i_clk_20M);  // Start taken here
    // Scramble the config ports since the set is already latched
    rnd = next_random();
    i_start_valid <= 1'b0;
    i_mode        <= ~mode_word;
    i_shift_a     <= rnd[31:16];
    i_shift_b     <= rnd[15:0];
    i_shift_c     <= ~rnd[31:16];
    i_bypass_a    <= rnd[31:8];
    i_bypass_b    <= ~rnd[31:8];
    i_bypass_c    <= rnd[23:0];
    i_angle_ready <= pick_ready(use_stalls);

    count   = 0;
    cycles  = 0;
    stalled = 1'b0;
    while (count < NUM_ITEMS && cycles < SET_LIMIT) begin
      @(negedge i_clk_20M);
      if (cycles == 0) begin
        compare_value("o_angle_valid", 32'(o_angle_valid), 32'd1);
      end
      cycles++;
      compare_value("o_start_ready", 32'(o_start_ready), 32'd0);
      if (stalled) begin
        compare_value("o_angle_valid", 32'(o_angle_valid), 32'd1);
        compare_value("o_angle", 32'(o_angle), 32'(held_angle));
        compare_value("o_phase", 32'(o_phase), 32'(held_phase));
        compare_value("o_cell", 32'(o_cell), 32'(held_cell));
      end
      stalled    = o_angle_valid && !i_angle_ready;
      held_angle = o_angle;
      held_phase = o_phase;
      held_cell  = o_cell;
      if (o_angle_valid && i_angle_ready) begin
        exp_phase = count / `CELLS_PER_PHASE;
        exp_cell  = count % `CELLS_PER_PHASE;
        exp_angle = expected[count*`ANGLE_W +: `ANGLE_W];
        compare_value($sformatf("o_phase[%0d]", count), 32'(o_phase), exp_phase);
        compare_value($sformatf("o_cell[%0d]", count), 32'(o_cell), exp_cell);
        compare_value($sformatf("o_angle[%0d]", count), 32'(o_angle), 32'(exp_angle));
        if (!use_bypass && !restart) begin
          case (exp_phase)
            0: closed = sa * `ANGLE_W'(exp_cell);
            1: closed = sa * `ANGLE_W'(`CELLS_PER_PHASE - 1) + sb * `ANGLE_W'(exp_cell + 1);
            default: closed = sa * `ANGLE_W'(`CELLS_PER_PHASE - 1) +
                              sb * `ANGLE_W'(`CELLS_PER_PHASE) + sc * `ANGLE_W'(exp_cell + 1);
          endcase
          compare_value($sformatf("o_angle[%0d]", count), 32'(o_angle), 32'(closed));
        end
        if (restart && exp_cell == 0) begin
          compare_value($sformatf("o_angle[%0d]", count), 32'(o_angle), 32'd0);
        end
        count++;
      end
      @(posedge i_clk_20M);
      i_angle_ready <= pick_ready(use_stalls);
    end
    if (count < NUM_ITEMS) begin
      timeout_count++;
      $display("Timeout: the output stream stopped after %0d of %0d items", count, NUM_ITEMS);
    end else begin
      @(negedge i_clk_20M);  // One cycle after the last transfer
      compare_value("o_start_ready", 32'(o_start_ready), 32'd1);
      compare_value("o_angle_valid", 32'(o_angle_valid), 32'd0);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    rng_state     = 32'hb1c8;
    error_count   = 0;
    timeout_count = 0;
    i_reset_n     = 1'b0;
    i_start_valid = 1'b0;
    i_mode        = '0;
    i_shift_a     = '0;
    i_shift_b     = '0;
    i_shift_c     = '0;
    i_bypass_a    = '0;
    i_bypass_b    = '0;
    i_bypass_c    = '0;
    i_angle_ready = 1'b0;
    repeat (5) @(posedge i_clk_20M);
    i_reset_n <= 1'b1;
    @(negedge i_clk_20M);
    compare_value("o_start_ready", 32'(o_start_ready), 32'd1);
    compare_value("o_angle_valid", 32'(o_angle_valid), 32'd0);

    run_set(1'b0, 1'b0, 1'b0);  // Chained with every cell active
    if (timeout_count == 0) begin
      run_set(1'b0, 1'b1, 1'b0);
    end
    if (timeout_count == 0) begin
      run_set(1'b1, 1'b1, 1'b1);  // Restart under back-pressure
    end
    if (timeout_count == 0) begin
      run_set(1'b0, 1'b1, 1'b1);
    end

    $display("Value errors: %0d, timeouts: %0d", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
